// File: exe_alu.sv
/*
 * Combinational integer ALU.
 * i_unsigned selects the compare used by slt/sltu and branches.
 * o_sum is always lhs + rhs, whatever the micro-op.
 */
`timescale 1ns/1ps
`include "exe_macros.svh"

module exe_alu (
    input  exe_pkg::uop_t i_uop,         // ALU micro-op
    input  exe_pkg::word_t i_lhs,        // Left operand
    input  exe_pkg::word_t i_rhs,        // Right operand, low bits are shamt
    input  logic           i_unsigned,   // Unsigned compare
    output exe_pkg::word_t o_result,     // Selected result
    output exe_pkg::word_t o_sum,        // Address / jalr adder
    output logic           o_lt,         // lhs < rhs
    output logic           o_eq          // lhs == rhs
);

    localparam int SHAMT_W = $clog2(`EXE_XLEN);

    logic [SHAMT_W-1:0] shamt;           // Shift amount

    assign shamt = i_rhs[SHAMT_W-1:0];
    assign o_sum = i_lhs + i_rhs;

    // Compare flags --------------------------------
    always_comb begin
        o_eq = (i_lhs == i_rhs);
        if (i_unsigned) begin
            o_lt = (i_lhs < i_rhs);
        end else begin
            o_lt = ($signed(i_lhs) < $signed(i_rhs));
        end
    end

    // Result select --------------------------------
    always_comb begin
        case (i_uop)
            `EXE_ALU_ADD:  o_result = o_sum;
            `EXE_ALU_SUB:  o_result = i_lhs - i_rhs;
            `EXE_ALU_XOR:  o_result = i_lhs ^ i_rhs;
            `EXE_ALU_OR:   o_result = i_lhs | i_rhs;
            `EXE_ALU_AND:  o_result = i_lhs & i_rhs;
            `EXE_ALU_SLT,
            `EXE_ALU_SLTU: o_result = {{(`EXE_XLEN-1){1'b0}}, o_lt}; // Signedness via i_unsigned
            `EXE_ALU_SLL:  o_result = i_lhs << shamt;
            `EXE_ALU_SRL:  o_result = i_lhs >> shamt;
            `EXE_ALU_SRA:  o_result = $signed(i_lhs) >>> shamt;
            default:       o_result = '0;
        endcase
    end

endmodule

// File: exe_ctrl_fsm.sv
/*
 * Execute stage controller.
 * A multiply holds o_busy from presentation until its product is issued.
 * Upstream must keep the multiply stable while o_busy is high.
 */
`timescale 1ns/1ps

module exe_ctrl_fsm (
    input  logic         g_clk,
    input  logic         g_resetn,
    input  logic         i_valid,      // Issue side valid
    input  exe_pkg::fu_e i_fu,         // Unit of the presented op
    input  logic         i_reg_busy,   // Output register cannot load
    input  logic         i_last,       // Final multiplier step
    input  logic         i_flush,
    output logic         o_busy,       // Stage busy to upstream
    output logic         o_issue,      // Load strobe for the register
    output logic         o_mul_start,  // Load multiplier operands
    output logic         o_mul_run     // Multiplier step enable
);

    exe_pkg::exe_state_e state;
    exe_pkg::exe_state_e state_nxt;
    logic                mul_req;      // Multiply presented

    assign mul_req     = i_valid && (i_fu == exe_pkg::FU_MUL);
    assign o_mul_start = mul_req && (state == exe_pkg::ST_IDLE) && !i_flush;
    assign o_mul_run   = (state == exe_pkg::ST_MUL_RUN);
    assign o_busy      = i_reg_busy || (mul_req && state != exe_pkg::ST_MUL_DONE);
    assign o_issue     = i_valid && !o_busy;   // Same as the upstream transfer

    // Next state -----------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            exe_pkg::ST_IDLE: begin
                if (o_mul_start) begin
                    state_nxt = exe_pkg::ST_MUL_RUN;
                end
            end
            exe_pkg::ST_MUL_RUN: begin
                if (i_last) begin
                    state_nxt = exe_pkg::ST_MUL_DONE;
                end
            end
            exe_pkg::ST_MUL_DONE: begin
                if (o_issue) begin
                    state_nxt = exe_pkg::ST_IDLE;   // Product taken
                end
            end
            default: state_nxt = exe_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn || i_flush) begin
            state <= exe_pkg::ST_IDLE;              // Flush drops any multiply
        end else begin
            state <= state_nxt;
        end
    end

    // Operands feed the multiplier until the product is issued
    a_mul_held: assert property (@(posedge g_clk) disable iff (!g_resetn || i_flush)
        state != exe_pkg::ST_IDLE |-> mul_req)
        else $error("multiply withdrawn before its product was issued");

endmodule

// File: exe_macros.svh
/*
 * Widths and micro-op codes for the execute stage.
 * Codes are only unique within one functional unit; the unit field
 * tells them apart. EXE_CNT_W must hold EXE_MUL_STEPS itself.
 */
`ifndef EXE_MACROS_SVH
`define EXE_MACROS_SVH

`define EXE_XLEN          32  // Data word width
`define EXE_UOP_W         5   // Micro-op width
`define EXE_REG_W         5   // Register number width
`define EXE_MUL_STEPS     32  // One shift-add step per multiplier bit
`define EXE_CNT_W         6   // Step counter width

// ALU micro-ops ------------------------------------
`define EXE_ALU_ADD       5'd0
`define EXE_ALU_SUB       5'd1
`define EXE_ALU_XOR       5'd2
`define EXE_ALU_OR        5'd3
`define EXE_ALU_AND       5'd4
`define EXE_ALU_SLT       5'd5
`define EXE_ALU_SLTU      5'd6
`define EXE_ALU_SLL       5'd7
`define EXE_ALU_SRL       5'd8
`define EXE_ALU_SRA       5'd9

// Branch unit micro-ops ----------------------------
`define EXE_CFU_BEQ       5'd0
`define EXE_CFU_BNE       5'd1
`define EXE_CFU_BLT       5'd2
`define EXE_CFU_BGE       5'd3
`define EXE_CFU_BLTU      5'd4
`define EXE_CFU_BGEU      5'd5
`define EXE_CFU_JAL       5'd6
`define EXE_CFU_JALR      5'd7
`define EXE_CFU_TAKEN     5'd8   // Resolved conditional branch
`define EXE_CFU_NOT_TAKEN 5'd9

// LSU and multiplier micro-ops ---------------------
`define EXE_LSU_LOAD      5'd0
`define EXE_LSU_STORE     5'd1
`define EXE_MUL_MUL       5'd0   // Low half of product
`define EXE_MUL_MULHU     5'd1   // High half, unsigned

`endif

// File: exe_mul_counter.sv
/*
 * Step counter for the multiplier.
 * Sits at EXE_MUL_STEPS after a full run until the next start.
 */
`timescale 1ns/1ps
`include "exe_macros.svh"

module exe_mul_counter (
    input  logic           g_clk,
    input  logic           g_resetn,
    input  logic           i_start,  // Multiply loaded this cycle
    input  logic           i_run,    // Shift-add step this cycle
    input  logic           i_flush,  // Abandon the multiply
    output exe_pkg::step_t o_step,   // Steps done so far
    output logic           o_last    // This is the final step
);

    always_ff @(posedge g_clk) begin
        if (!g_resetn || i_start || i_flush) begin
            o_step <= '0;
        end else if (i_run) begin
            o_step <= o_step + 1'b1;
        end
    end

    assign o_last = (o_step == exe_pkg::step_t'(`EXE_MUL_STEPS - 1));

    a_step_range: assert property (@(posedge g_clk) disable iff (!g_resetn)
        o_step <= exe_pkg::step_t'(`EXE_MUL_STEPS))
        else $error("multiplier step count overran");

endmodule

// File: exe_multiplier.sv
/*
 * Unsigned shift-add multiplier, one multiplier bit per run cycle.
 * The multiplier operand shares the low half of the product register.
 * o_product is final after EXE_MUL_STEPS run cycles.
 */
`timescale 1ns/1ps
`include "exe_macros.svh"

module exe_multiplier (
    input  logic            g_clk,
    input  logic            g_resetn,
    input  logic            i_start,   // Load operands
    input  logic            i_run,     // Perform one step
    input  exe_pkg::word_t  i_lhs,     // Multiplicand
    input  exe_pkg::word_t  i_rhs,     // Multiplier
    output exe_pkg::dword_t o_product  // Partial, then final product
);

    exe_pkg::word_t      mcand;        // Held for the whole run
    logic [`EXE_XLEN:0]  part_sum;     // Upper half plus addend, with carry
    exe_pkg::word_t      addend;       // Multiplicand or zero

    assign addend   = o_product[0] ? mcand : '0;   // Current multiplier bit
    assign part_sum = {1'b0, o_product[2*`EXE_XLEN-1:`EXE_XLEN]} + {1'b0, addend};

    always_ff @(posedge g_clk) begin
        if (i_start) begin
            mcand <= i_lhs;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            o_product <= '0;
        end else if (i_start) begin
            o_product <= {{`EXE_XLEN{1'b0}}, i_rhs};           // Clear accumulator
        end else if (i_run) begin
            o_product <= {part_sum, o_product[`EXE_XLEN-1:1]}; // Add then shift right
        end
    end

endmodule

// File: exe_pipe_reg.sv
/*
 * One-entry output register with valid/busy handshake.
 * Flush wins over a load on the same edge.
 */
`timescale 1ns/1ps

module exe_pipe_reg (
    input  logic             g_clk,
    input  logic             g_resetn,
    input  logic             i_flush,
    input  logic             i_issue,     // Load i_next
    input  exe_pkg::result_t i_next,      // Record from the stage
    input  logic             i_s3_busy,   // Downstream stall
    output logic             o_busy,      // Register full and held
    output logic             o_s3_valid,
    output exe_pkg::result_t o_s3
);

    assign o_busy = o_s3_valid && i_s3_busy;

    always_ff @(posedge g_clk) begin
        if (!g_resetn || i_flush) begin
            o_s3_valid <= 1'b0;
        end else if (i_issue) begin
            o_s3_valid <= 1'b1;
        end else if (!i_s3_busy) begin
            o_s3_valid <= 1'b0;                // Consumed, nothing new
        end
    end

    always_ff @(posedge g_clk) begin
        if (i_issue) begin
            o_s3 <= i_next;                    // Payload only
        end
    end

    // Controller must never load over a stalled record
    a_hold_stable: assert property (@(posedge g_clk) disable iff (!g_resetn)
        o_s3_valid && i_s3_busy && !i_flush |=> o_s3_valid && $stable(o_s3))
        else $error("output record changed under back-pressure");

endmodule

// File: exe_pkg.sv
/*
 * Types shared by the execute stage and its testbench.
 * Widths come from the macros header.
 */
`include "exe_macros.svh"

package exe_pkg;

    typedef logic [`EXE_XLEN-1:0]   word_t;      // Data word
    typedef logic [2*`EXE_XLEN-1:0] dword_t;     // Full product
    typedef logic [`EXE_UOP_W-1:0]  uop_t;       // Micro-op code
    typedef logic [`EXE_REG_W-1:0]  reg_addr_t;  // Register number
    typedef logic [`EXE_CNT_W-1:0]  step_t;      // Multiplier step count

    typedef enum logic [1:0] {
        FU_ALU,                                  // Integer ALU
        FU_CFU,                                  // Branches and jumps
        FU_LSU,                                  // Load/store address
        FU_MUL                                   // Iterative multiplier
    } fu_e;

    typedef enum logic [1:0] {
        ST_IDLE,                                 // Single cycle ops pass through
        ST_MUL_RUN,                              // Shift-add steps in progress
        ST_MUL_DONE                              // Product waiting for the register
    } exe_state_e;

    // Decoded operation from the issue stage
    typedef struct packed {
        reg_addr_t rd;                           // Destination register
        fu_e       fu;                           // Target unit
        uop_t      uop;                          // Unit-local micro-op
        word_t     a;                            // Operand A
        word_t     b;                            // Operand B
        word_t     c;                            // Operand C, store data or jump target
    } issue_t;

    // Record handed to writeback
    typedef struct packed {
        reg_addr_t rd;
        fu_e       fu;
        uop_t      uop;                          // Branches carry taken/not-taken
        word_t     opr_a;                        // Result, address or target
        word_t     opr_b;                        // Store data, else zero
    } result_t;

    typedef struct packed {
        reg_addr_t rd;                           // Register being produced
        word_t     wdata;                        // Value to forward
        logic      load;                         // Value not known until memory
    } fwd_t;

endpackage

// File: exe_result_sel.sv
/*
 * Builds the next output record and the forwarding record.
 * The multiplier product is only meaningful in the done state.
 */
`timescale 1ns/1ps
`include "exe_macros.svh"

module exe_result_sel (
    input  exe_pkg::issue_t  i_issue,        // Operation being executed
    input  exe_pkg::word_t   i_alu_result,   // ALU result
    input  exe_pkg::word_t   i_sum,          // a + b
    input  exe_pkg::dword_t  i_product,      // Full unsigned product
    input  logic             i_lt,           // Compare flags from the ALU
    input  logic             i_eq,
    output logic             o_alu_unsigned, // Ask ALU for unsigned compare
    output exe_pkg::result_t o_next,         // Record for the pipe register
    output exe_pkg::fwd_t    o_fwd           // Forwarding record
);

    logic is_alu;
    logic is_cfu;
    logic cond;                              // Conditional branch micro-op
    logic taken;                             // Compare outcome

    assign is_alu = (i_issue.fu == exe_pkg::FU_ALU);
    assign is_cfu = (i_issue.fu == exe_pkg::FU_CFU);

    assign o_alu_unsigned = (is_alu && i_issue.uop == `EXE_ALU_SLTU) ||
                            (is_cfu && (i_issue.uop == `EXE_CFU_BLTU ||
                                        i_issue.uop == `EXE_CFU_BGEU));

    // Branch resolution ----------------------------
    always_comb begin
        cond  = 1'b1;
        taken = 1'b0;
        case (i_issue.uop)
            `EXE_CFU_BEQ:  taken = i_eq;
            `EXE_CFU_BNE:  taken = !i_eq;
            `EXE_CFU_BLT,
            `EXE_CFU_BLTU: taken = i_lt;       // Signedness set by o_alu_unsigned
            `EXE_CFU_BGE,
            `EXE_CFU_BGEU: taken = !i_lt;
            default:       cond  = 1'b0;       // Jumps keep their uop
        endcase
    end

    // Per-unit operands ----------------------------
    always_comb begin
        o_next.rd    = i_issue.rd;
        o_next.fu    = i_issue.fu;
        o_next.uop   = i_issue.uop;
        o_next.opr_a = '0;
        o_next.opr_b = '0;
        case (i_issue.fu)
            exe_pkg::FU_ALU: o_next.opr_a = i_alu_result;
            exe_pkg::FU_CFU: begin
                if (cond) begin
                    o_next.uop = taken ? `EXE_CFU_TAKEN : `EXE_CFU_NOT_TAKEN;
                end
                if (i_issue.uop == `EXE_CFU_JALR) begin
                    o_next.opr_a = {i_sum[`EXE_XLEN-1:1], 1'b0};     // Register target
                end else begin
                    o_next.opr_a = {i_issue.c[`EXE_XLEN-1:1], 1'b0}; // Precomputed target
                end
            end
            exe_pkg::FU_LSU: begin
                o_next.opr_a = i_sum;                  // Effective address
                if (i_issue.uop == `EXE_LSU_STORE) begin
                    o_next.opr_b = i_issue.c;          // Store data
                end
            end
            default: begin                             // Multiplier
                if (i_issue.uop == `EXE_MUL_MULHU) begin
                    o_next.opr_a = i_product[2*`EXE_XLEN-1:`EXE_XLEN];
                end else begin
                    o_next.opr_a = i_product[`EXE_XLEN-1:0];
                end
            end
        endcase
    end

    assign o_fwd.rd    = i_issue.rd;
    assign o_fwd.wdata = o_next.opr_a;
    assign o_fwd.load  = (i_issue.fu == exe_pkg::FU_LSU) && (i_issue.uop == `EXE_LSU_LOAD);

endmodule

// File: exe_top.sv
/*
 * Execute stage top level.
 * o_busy and o_fwd are combinational from the issue inputs.
 */
`timescale 1ns/1ps

module exe_top (
    input  logic             g_clk,
    input  logic             g_resetn,
    input  logic             i_valid,     // Issue side handshake
    input  exe_pkg::issue_t  i_issue,
    output logic             o_busy,
    input  logic             i_flush,
    output exe_pkg::fwd_t    o_fwd,       // Forwarding to decode
    output logic             o_s3_valid,  // Writeback side handshake
    output exe_pkg::result_t o_s3,
    input  logic             i_s3_busy
);

    logic             reg_busy;
    logic             issue;
    logic             mul_start;
    logic             mul_run;
    logic             mul_last;
    logic             alu_unsigned;
    logic             alu_lt;
    logic             alu_eq;
    exe_pkg::word_t   alu_result;
    exe_pkg::word_t   alu_sum;
    exe_pkg::dword_t  product;
    exe_pkg::result_t next_rec;

    exe_ctrl_fsm u_ctrl (
        .g_clk(g_clk), .g_resetn(g_resetn), .i_valid(i_valid), .i_fu(i_issue.fu),
        .i_reg_busy(reg_busy), .i_last(mul_last), .i_flush(i_flush), .o_busy(o_busy),
        .o_issue(issue), .o_mul_start(mul_start), .o_mul_run(mul_run)
    );

    exe_mul_counter u_cnt (
        .g_clk(g_clk), .g_resetn(g_resetn), .i_start(mul_start), .i_run(mul_run),
        .i_flush(i_flush), .o_step(), .o_last(mul_last)
    );

    exe_multiplier u_mul (
        .g_clk(g_clk), .g_resetn(g_resetn), .i_start(mul_start), .i_run(mul_run),
        .i_lhs(i_issue.a), .i_rhs(i_issue.b), .o_product(product)
    );

    exe_alu u_alu (
        .i_uop(i_issue.uop), .i_lhs(i_issue.a), .i_rhs(i_issue.b),
        .i_unsigned(alu_unsigned), .o_result(alu_result), .o_sum(alu_sum),
        .o_lt(alu_lt), .o_eq(alu_eq)
    );

    exe_result_sel u_sel (
        .i_issue(i_issue), .i_alu_result(alu_result), .i_sum(alu_sum),
        .i_product(product), .i_lt(alu_lt), .i_eq(alu_eq),
        .o_alu_unsigned(alu_unsigned), .o_next(next_rec), .o_fwd(o_fwd)
    );

    exe_pipe_reg u_preg (
        .g_clk(g_clk), .g_resetn(g_resetn), .i_flush(i_flush), .i_issue(issue),
        .i_next(next_rec), .i_s3_busy(i_s3_busy), .o_busy(reg_busy),
        .o_s3_valid(o_s3_valid), .o_s3(o_s3)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_exe_top -f sim.f

./obj_dir/Vtb_exe_top > sim.log 2>&1 || true
cat sim.log

if grep -qx "All tests passed" sim.log; then
    echo "run_sim: PASS"
else
    echo "run_sim: FAIL"
    exit 1
fi

// File: sim.f
+incdir+.
exe_pkg.sv
exe_alu.sv
exe_result_sel.sv
exe_mul_counter.sv
exe_multiplier.sv
exe_ctrl_fsm.sv
exe_pipe_reg.sv
exe_top.sv
tb_exe_top.sv

// File: tb_exe_top.sv
/*
 * Self-checking testbench for the execute stage.
 * A reference model queues the expected record of every accepted op.
 * Concurrent assertions compare each consumed record with the queue head.
 */
`timescale 1ns/1ps
`include "exe_macros.svh"

module tb_exe_top;

    localparam int WAIT_LIMIT = 200;                   // Cycles allowed per wait
    localparam int MUL_WAIT   = `EXE_MUL_STEPS + 2;    // Load, run steps, issue

    logic             g_clk;
    logic             g_resetn;
    logic             i_valid;
    exe_pkg::issue_t  i_issue;
    logic             o_busy;
    logic             i_flush;
    exe_pkg::fwd_t    o_fwd;
    logic             o_s3_valid;
    exe_pkg::result_t o_s3;
    logic             i_s3_busy = 1'b0;

    integer           seed;
    int               err_cnt;
    int               pass_cnt;
    int               fail_cnt;
    logic             timed_out;
    logic             bp_en;                           // Random downstream stalls
    logic             hold_busy;                       // Force a stall
    int               bp_left;                         // Cycles left in this stretch

    // Scoreboard state ---------------------------------
    exe_pkg::result_t sb_q[$];                         // Expected records in order
    exe_pkg::result_t exp_rec;                         // Model of the presented op
    logic             exp_load;
    exe_pkg::result_t exp_head = '0;                   // Queue head as of last edge
    int               exp_cnt = 0;
    int               n_issued = 0;
    logic             overlap_seen = 1'b0;             // Issue while a record was held

    exe_top UUT (
        .g_clk(g_clk), .g_resetn(g_resetn), .i_valid(i_valid), .i_issue(i_issue),
        .o_busy(o_busy), .i_flush(i_flush), .o_fwd(o_fwd), .o_s3_valid(o_s3_valid),
        .o_s3(o_s3), .i_s3_busy(i_s3_busy)
    );

    always #50 g_clk = ~g_clk;

    // Expected record from the ISA rules
    function automatic exe_pkg::result_t model_result(input exe_pkg::issue_t op);
        exe_pkg::result_t r;
        exe_pkg::dword_t  prod;
        exe_pkg::word_t   sum;
        logic [4:0]       sh;
        logic             take;
        r        = '0;
        r.rd     = op.rd;
        r.fu     = op.fu;
        r.uop    = op.uop;
        sum      = op.a + op.b;
        sh       = op.b[4:0];                          // RV32 shamt
        prod     = exe_pkg::dword_t'(op.a) * exe_pkg::dword_t'(op.b);
        take     = 1'b0;
        case (op.fu)
            exe_pkg::FU_ALU: begin
                case (op.uop)
                    `EXE_ALU_ADD:  r.opr_a = sum;
                    `EXE_ALU_SUB:  r.opr_a = op.a - op.b;
                    `EXE_ALU_XOR:  r.opr_a = op.a ^ op.b;
                    `EXE_ALU_OR:   r.opr_a = op.a | op.b;
                    `EXE_ALU_AND:  r.opr_a = op.a & op.b;
                    `EXE_ALU_SLT:  r.opr_a = exe_pkg::word_t'($signed(op.a) < $signed(op.b));
                    `EXE_ALU_SLTU: r.opr_a = exe_pkg::word_t'(op.a < op.b);
                    `EXE_ALU_SLL:  r.opr_a = op.a << sh;
                    `EXE_ALU_SRL:  r.opr_a = op.a >> sh;
                    default:       r.opr_a = $signed(op.a) >>> sh;   // sra
                endcase
            end
            exe_pkg::FU_CFU: begin
                case (op.uop)
                    `EXE_CFU_BEQ:  take = (op.a == op.b);
                    `EXE_CFU_BNE:  take = (op.a != op.b);
                    `EXE_CFU_BLT:  take = ($signed(op.a) < $signed(op.b));
                    `EXE_CFU_BGE:  take = ($signed(op.a) >= $signed(op.b));
                    `EXE_CFU_BLTU: take = (op.a < op.b);
                    `EXE_CFU_BGEU: take = (op.a >= op.b);
                    default:       take = 1'b0;
                endcase
                if (op.uop <= `EXE_CFU_BGEU) begin
                    r.uop = take ? `EXE_CFU_TAKEN : `EXE_CFU_NOT_TAKEN;
                end
                r.opr_a = ((op.uop == `EXE_CFU_JALR) ? sum : op.c) & ~exe_pkg::word_t'(1);
            end
            exe_pkg::FU_LSU: begin
                r.opr_a = sum;                         // Effective address
                r.opr_b = (op.uop == `EXE_LSU_STORE) ? op.c : '0;
            end
            default: begin
                r.opr_a = (op.uop == `EXE_MUL_MULHU) ? prod[2*`EXE_XLEN-1:`EXE_XLEN]
                                                    : prod[`EXE_XLEN-1:0];
            end
        endcase
        return r;
    endfunction

    function automatic exe_pkg::issue_t random_op(input exe_pkg::fu_e fu,
                                                  input exe_pkg::uop_t uop);
        exe_pkg::issue_t op;
        op.rd  = exe_pkg::reg_addr_t'($random(seed));
        op.fu  = fu;
        op.uop = uop;
        op.a   = $random(seed);
        op.b   = $random(seed);
        op.c   = $random(seed);
        return op;
    endfunction

    // Scoreboard pops on consume then pushes on transfer
    always @(posedge g_clk) begin
        if (!g_resetn || i_flush) begin
            sb_q.delete();                             // Flush drops everything in flight
        end else begin
            if (o_s3_valid && !i_s3_busy) begin
                if (sb_q.size() > 0) void'(sb_q.pop_front());
            end
            if (i_valid && !o_busy) begin
                if (o_s3_valid) overlap_seen = 1'b1;
                sb_q.push_back(exp_rec);
                n_issued++;
            end
        end
        exp_head <= (sb_q.size() > 0) ? sb_q[0] : '0;
        exp_cnt  <= sb_q.size();
    end

    // Downstream stall pattern
    always @(negedge g_clk) begin
        if (hold_busy) begin
            i_s3_busy = 1'b1;
        end else if (!bp_en) begin
            i_s3_busy = 1'b0;
            bp_left   = 0;
        end else if (bp_left == 0) begin
            i_s3_busy = $random(seed) % 2 != 0;
            bp_left   = 1 + $unsigned($random(seed)) % 6;    // Stretch length
        end else begin
            bp_left = bp_left - 1;
        end
    end

    // Checks -------------------------------------------
    a_result: assert property (@(posedge g_clk) disable iff (!g_resetn || i_flush)
        o_s3_valid && !i_s3_busy |-> exp_cnt != 0 && o_s3 == exp_head)
        else begin
            $display("mismatch at %0t: record %h, expected %h (%0d queued)",
                     $time, o_s3, exp_head, exp_cnt);
            err_cnt++;
        end

    a_fwd: assert property (@(posedge g_clk) disable iff (!g_resetn || i_flush)
        i_valid && !o_busy |-> o_fwd.rd == exp_rec.rd && o_fwd.wdata == exp_rec.opr_a &&
                               o_fwd.load == exp_load)
        else begin
            $display("mismatch at %0t: forward %h, expected rd %0d data %h load %b",
                     $time, o_fwd, exp_rec.rd, exp_rec.opr_a, exp_load);
            err_cnt++;
        end

    a_hold: assert property (@(posedge g_clk) disable iff (!g_resetn || i_flush)
        o_s3_valid && i_s3_busy |=> o_s3_valid && $stable(o_s3))
        else begin
            $display("mismatch at %0t: output record changed while stalled", $time);
            err_cnt++;
        end

    // Driver tasks -------------------------------------
    task automatic note_timeout(input string what);
        $display("timeout: %s did not happen within %0d cycles at %0t", what, WAIT_LIMIT, $time);
        timed_out = 1'b1;
    endtask

    // Entered just after a falling edge and returns after the transfer
    task automatic send_op(input exe_pkg::issue_t op, output int waited);
        int start;
        waited   = 0;
        i_issue  = op;
        i_valid  = 1'b1;
        exp_rec  = model_result(op);
        exp_load = (op.fu == exe_pkg::FU_LSU) && (op.uop == `EXE_LSU_LOAD);
        start    = n_issued;
        while (!timed_out && n_issued == start) begin
            @(negedge g_clk);
            waited++;
            if (waited > WAIT_LIMIT) note_timeout("issue handshake");
        end
    endtask

    task automatic drain_output();
        int waited;
        waited  = 0;
        i_valid = 1'b0;
        while (!timed_out && (sb_q.size() != 0 || o_s3_valid)) begin
            @(negedge g_clk);
            waited++;
            if (waited > WAIT_LIMIT) note_timeout("output drain");
        end
    endtask

    task automatic finish_test(input string name, input int errs_at_start);
        if (err_cnt == errs_at_start && !timed_out) begin
            pass_cnt++;
            $display("test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("test %s: FAILED", name);
        end
    endtask

    // Tests --------------------------------------------
    task automatic reset_state();
        int errs;
        errs = err_cnt;
        assert (!o_s3_valid && !o_busy) else begin
            $display("mismatch at %0t: valid %b busy %b after reset", $time, o_s3_valid, o_busy);
            err_cnt++;
        end
        finish_test("reset", errs);
    endtask

    task automatic alu_ops();
        int errs;
        int waited;
        errs = err_cnt;
        for (int i = 0; i < 40; i++) begin
            send_op(random_op(exe_pkg::FU_ALU, exe_pkg::uop_t'(i % 10)), waited);
        end
        drain_output();
        finish_test("alu", errs);
    endtask

    task automatic branch_ops();
        int              errs;
        int              waited;
        exe_pkg::issue_t op;
        errs = err_cnt;
        for (int i = 0; i < 24; i++) begin
            op = random_op(exe_pkg::FU_CFU, exe_pkg::uop_t'(i % 8));
            if (i % 3 == 0) op.b = op.a;               // Hit the equal case
            send_op(op, waited);
        end
        drain_output();
        finish_test("branch", errs);
    endtask

    task automatic load_store_ops();
        int errs;
        int waited;
        errs = err_cnt;
        for (int i = 0; i < 20; i++) begin
            send_op(random_op(exe_pkg::FU_LSU, exe_pkg::uop_t'(i % 2)), waited);
        end
        drain_output();
        finish_test("load_store", errs);
    endtask

    task automatic multiply_ops();
        int errs;
        int waited;
        errs = err_cnt;
        for (int i = 0; i < 8; i++) begin
            send_op(random_op(exe_pkg::FU_MUL, exe_pkg::uop_t'(i % 2)), waited);
            assert (waited == MUL_WAIT) else begin
                $display("mismatch at %0t: multiply issued after %0d cycles, expected %0d",
                         $time, waited, MUL_WAIT);
                err_cnt++;
            end
        end
        drain_output();
        finish_test("multiply", errs);
    endtask

    task automatic back_pressure_run();
        int           errs;
        int           waited;
        int           lim;
        logic [31:0]  pick;
        exe_pkg::fu_e fu;
        errs         = err_cnt;
        overlap_seen = 1'b0;
        bp_en        = 1'b1;
        for (int i = 0; i < 30; i++) begin
            pick = $random(seed);
            fu   = exe_pkg::fu_e'(pick[1:0]);
            lim  = (fu == exe_pkg::FU_ALU) ? 10 : (fu == exe_pkg::FU_CFU) ? 8 : 2;
            send_op(random_op(fu, exe_pkg::uop_t'($unsigned($random(seed)) % lim)), waited);
        end
        drain_output();
        bp_en = 1'b0;
        assert (overlap_seen) else begin
            $display("no op was ever issued while a record sat in the output register");
            err_cnt++;
        end
        finish_test("back_pressure", errs);
    endtask

    task automatic flush_during_multiply();
        int errs;
        int waited;
        int issued;
        errs      = err_cnt;
        hold_busy = 1'b1;
        send_op(random_op(exe_pkg::FU_ALU, `EXE_ALU_ADD), waited);  // Parked record
        i_issue   = random_op(exe_pkg::FU_MUL, `EXE_MUL_MUL);
        i_valid   = 1'b1;
        issued    = n_issued;
        repeat (10) @(negedge g_clk);                  // Part way into the run
        i_valid   = 1'b0;
        i_flush   = 1'b1;
        @(negedge g_clk);
        i_flush   = 1'b0;
        hold_busy = 1'b0;
        assert (!o_s3_valid && !o_busy && n_issued == issued && sb_q.size() == 0) else begin
            $display("mismatch at %0t: valid %b busy %b after flush", $time, o_s3_valid, o_busy);
            err_cnt++;
        end
        send_op(random_op(exe_pkg::FU_MUL, `EXE_MUL_MULHU), waited);
        assert (waited == MUL_WAIT) else begin
            $display("mismatch at %0t: multiply after flush took %0d cycles", $time, waited);
            err_cnt++;
        end
        send_op(random_op(exe_pkg::FU_ALU, `EXE_ALU_SRA), waited);
        drain_output();
        finish_test("flush", errs);
    endtask

    initial begin
        seed      = 32'h94b9e01b;
        g_clk     = 1'b0;
        g_resetn  = 1'b0;
        i_valid   = 1'b0;
        i_issue   = '0;
        i_flush   = 1'b0;
        exp_rec   = '0;
        exp_load  = 1'b0;
        err_cnt   = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        timed_out = 1'b0;
        bp_en     = 1'b0;
        hold_busy = 1'b0;
        bp_left   = 0;
        repeat (5) @(negedge g_clk);                   // Five clocks in reset
        g_resetn = 1'b1;
        @(negedge g_clk);
        reset_state();
        alu_ops();
        branch_ops();
        load_store_ops();
        multiply_ops();
        back_pressure_run();
        flush_during_multiply();
        $display("tests passed %0d, failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0 && fail_cnt == 0 && !timed_out) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
